//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall
TOP       := tb_l1d_subsystem
RTL_TOP   := l1d_subsystem
FILELIST  := tb.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- common/l1d_pkg.sv
/*
 * Shared definitions for the L1 data-side subsystem
 *   - address and data widths, byte offset split
 *   - prefetcher configuration word width
 *   - stride prefetcher param fields and param union
 */
package l1d_pkg;

  localparam int ADDR_W = 32;  // Byte address
  localparam int DATA_W = 64;  // One word per cache line
  localparam int CFG_W  = 64;  // Prefetcher config words
  localparam int OFFS_W = 3;   // Byte offset inside a word, ignored by the cache

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  // Stride prefetcher param register layout
  typedef struct packed {
    logic [31:0] rsvd;
    logic [15:0] nlines;  // Lines fetched per trigger
    logic [15:0] stride;  // Bytes between two prefetches
  } hwpf_param_fields_t;

  // Same word, seen raw for readback or split into fields
  typedef union packed {
    logic [CFG_W-1:0]   raw;
    hwpf_param_fields_t fields;
  } hwpf_param_u;

endpackage

//--- dcache/dcache_array.sv
/*
 * Direct-mapped cache storage
 *   - valid bits, tags and one data word per set
 *   - combinational lookup, single line write, invalidate-all
 */
`timescale 1ns/1ps

module dcache_array import l1d_pkg::*; #(
  parameter int unsigned CacheSets = 16
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  addr_t rd_addr_i,
  output logic  hit_o,
  output data_t rd_data_o,
  input  logic  wr_en_i,
  input  addr_t wr_addr_i,
  input  data_t wr_data_i,
  input  logic  inval_all_i
);

  localparam int IdxW = $clog2(CacheSets);
  localparam int TagW = ADDR_W - OFFS_W - IdxW;

  logic [CacheSets-1:0] valid_q;
  logic [TagW-1:0]      tag_q  [CacheSets];
  data_t                data_q [CacheSets];

  logic [IdxW-1:0] rd_idx, wr_idx;

  assign rd_idx = rd_addr_i[OFFS_W +: IdxW];
  assign wr_idx = wr_addr_i[OFFS_W +: IdxW];

  assign hit_o     = valid_q[rd_idx] && (tag_q[rd_idx] == rd_addr_i[ADDR_W-1 -: TagW]);
  assign rd_data_o = data_q[rd_idx];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (inval_all_i) begin
      valid_q <= '0;  // Flush
    end else if (wr_en_i) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      tag_q[wr_idx]  <= wr_addr_i[ADDR_W-1 -: TagW];
      data_q[wr_idx] <= wr_data_i;
    end
  end

endmodule

//--- dcache/dcache_ctrl.sv
/*
 * Data cache controller
 *   - idle, lookup, memory wait and ack states
 *   - load hit/refill, write-through stores, silent prefetch refill
 *   - flush with one-cycle acknowledge, load-miss event
 */
`timescale 1ns/1ps

module dcache_ctrl import l1d_pkg::*; #(
  parameter int unsigned CacheSets = 16
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  core_req_i,
  input  logic  core_we_i,
  input  logic  core_pf_i,
  input  addr_t core_addr_i,
  input  data_t core_wdata_i,
  output logic  core_ack_o,
  output data_t core_rdata_o,
  input  logic  flush_i,
  output logic  flush_ack_o,
  output logic  miss_o,
  output logic  mem_req_o,
  output logic  mem_we_o,
  output addr_t mem_addr_o,
  output data_t mem_wdata_o,
  input  logic  mem_ack_i,
  input  data_t mem_rdata_i
);

  localparam logic [1:0] StIdle    = 2'd0;
  localparam logic [1:0] StLookup  = 2'd1;
  localparam logic [1:0] StMemWait = 2'd2;
  localparam logic [1:0] StAck     = 2'd3;

  logic [1:0] state_q;
  logic       ack_q, mem_req_q, miss_q, flush_ack_q;

  // Latched request
  addr_t addr_q;
  data_t wdata_q, rdata_q;
  logic  we_q, pf_q;

  logic  hit, wr_en, flush_go, accept;
  data_t arr_rdata, wr_data;

  //////////////////////////////////////////
  // Storage
  //////////////////////////////////////////

  assign flush_go = (state_q == StIdle) && flush_i && !flush_ack_q;
  assign accept   = (state_q == StIdle) && !flush_go && core_req_i && !mem_ack_i;

  // Refill on read miss, update on store hit
  assign wr_en   = (state_q == StMemWait) && mem_req_q && mem_ack_i && (!we_q || hit);
  assign wr_data = we_q ? wdata_q : mem_rdata_i;

  dcache_array #(
    .CacheSets (CacheSets)
  ) i_dcache_array (
    .clk_i,
    .rst_ni,
    .rd_addr_i   (addr_q),
    .hit_o       (hit),
    .rd_data_o   (arr_rdata),
    .wr_en_i     (wr_en),
    .wr_addr_i   (addr_q),
    .wr_data_i   (wr_data),
    .inval_all_i (flush_go)
  );

  //////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= StIdle;
      ack_q       <= 1'b0;
      mem_req_q   <= 1'b0;
      miss_q      <= 1'b0;
      flush_ack_q <= 1'b0;
    end else begin
      miss_q      <= 1'b0;
      flush_ack_q <= flush_go;  // Single-cycle pulse
      case (state_q)
        StIdle: begin
          if (accept) state_q <= StLookup;
        end
        StLookup: begin
          if (we_q || !hit) begin
            mem_req_q <= 1'b1;  // Write-through or refill
            state_q   <= StMemWait;
          end else begin
            state_q <= StAck;
          end
          miss_q <= !we_q && !pf_q && !hit;  // Demand loads only
        end
        StMemWait: begin
          if (mem_ack_i) begin
            mem_req_q <= 1'b0;
            state_q   <= StAck;
          end
        end
        default: begin
          if (!ack_q) begin
            ack_q <= 1'b1;
          end else if (!core_req_i) begin
            ack_q   <= 1'b0;
            state_q <= StIdle;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q  <= core_addr_i;
      wdata_q <= core_wdata_i;
      we_q    <= core_we_i;
      pf_q    <= core_pf_i;
    end
    if (state_q == StLookup) rdata_q <= arr_rdata;
    if (wr_en && !we_q)      rdata_q <= mem_rdata_i;  // Refill data
  end

  assign core_ack_o   = ack_q;
  assign core_rdata_o = rdata_q;
  assign flush_ack_o  = flush_ack_q;
  assign miss_o       = miss_q;

  assign mem_req_o   = mem_req_q;
  assign mem_we_o    = we_q;
  assign mem_addr_o  = addr_q;
  assign mem_wdata_o = wdata_q;

endmodule

//--- hwpf/hwpf_stride_arbiter.sv
/*
 * Stride prefetcher array
 *   - one engine per configuration slot
 *   - lowest-index grant held through the transfer
 *   - status word with enables and busy flags
 */
`timescale 1ns/1ps

module hwpf_stride_arbiter import l1d_pkg::*; #(
  parameter int unsigned NrHwPrefetchers = 2
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic [NrHwPrefetchers-1:0]            hwpf_base_set_i,
  input  logic [NrHwPrefetchers-1:0][CFG_W-1:0] hwpf_base_i,
  output logic [NrHwPrefetchers-1:0][CFG_W-1:0] hwpf_base_o,
  input  logic [NrHwPrefetchers-1:0]            hwpf_param_set_i,
  input  logic [NrHwPrefetchers-1:0][CFG_W-1:0] hwpf_param_i,
  output logic [NrHwPrefetchers-1:0][CFG_W-1:0] hwpf_param_o,
  input  logic [NrHwPrefetchers-1:0]            hwpf_throttle_set_i,
  input  logic [NrHwPrefetchers-1:0][CFG_W-1:0] hwpf_throttle_i,
  output logic [NrHwPrefetchers-1:0][CFG_W-1:0] hwpf_throttle_o,
  output logic [CFG_W-1:0]                      hwpf_status_o,
  input  logic                                  snoop_valid_i,
  input  addr_t                                 snoop_addr_i,
  output logic                                  pf_req_o,
  output addr_t                                 pf_addr_o,
  input  logic                                  pf_ack_i
);

  logic [NrHwPrefetchers-1:0]             eng_req, eng_ack, enabled, busy;
  logic [NrHwPrefetchers-1:0]             gnt_q, pick;
  logic [NrHwPrefetchers-1:0][ADDR_W-1:0] eng_addr;

  for (genvar i = 0; i < NrHwPrefetchers; i++) begin : gen_engine
    hwpf_stride_engine i_hwpf_stride_engine (
      .clk_i,
      .rst_ni,
      .base_set_i     (hwpf_base_set_i[i]),
      .base_i         (hwpf_base_i[i]),
      .base_o         (hwpf_base_o[i]),
      .param_set_i    (hwpf_param_set_i[i]),
      .param_i        (hwpf_param_i[i]),
      .param_o        (hwpf_param_o[i]),
      .throttle_set_i (hwpf_throttle_set_i[i]),
      .throttle_i     (hwpf_throttle_i[i]),
      .throttle_o     (hwpf_throttle_o[i]),
      .snoop_valid_i,
      .snoop_addr_i,
      .pf_req_o       (eng_req[i]),
      .pf_addr_o      (eng_addr[i]),
      .pf_ack_i       (eng_ack[i]),
      .enabled_o      (enabled[i]),
      .busy_o         (busy[i])
    );
  end

  assign pick = eng_req & (~eng_req + 1'b1);  // Lowest set bit

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_q <= '0;
    end else if (gnt_q == '0) begin
      if (!pf_ack_i) gnt_q <= pick;
    end else if (!pf_req_o && !pf_ack_i) begin
      gnt_q <= '0;  // Four-phase cycle closed
    end
  end

  always_comb begin
    pf_addr_o = '0;
    for (int i = 0; i < NrHwPrefetchers; i++) begin
      if (gnt_q[i]) pf_addr_o = eng_addr[i];
    end
  end

  assign pf_req_o = |(gnt_q & eng_req);
  assign eng_ack  = gnt_q & {NrHwPrefetchers{pf_ack_i}};

  // Enables from bit 0, busy flags from bit 32
  assign hwpf_status_o = {{(32-NrHwPrefetchers){1'b0}}, busy,
                          {(32-NrHwPrefetchers){1'b0}}, enabled};

endmodule

//--- hwpf/hwpf_stride_engine.sv
/*
 * Stride prefetch engine
 *   - base, param and throttle registers with readback
 *   - triggers on a snooped access to the base address
 *   - issues nlines prefetches, then advances the base
 */
`timescale 1ns/1ps

module hwpf_stride_engine import l1d_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             base_set_i,
  input  logic [CFG_W-1:0] base_i,
  output logic [CFG_W-1:0] base_o,
  input  logic             param_set_i,
  input  logic [CFG_W-1:0] param_i,
  output logic [CFG_W-1:0] param_o,
  input  logic             throttle_set_i,
  input  logic [CFG_W-1:0] throttle_i,
  output logic [CFG_W-1:0] throttle_o,
  input  logic             snoop_valid_i,
  input  addr_t            snoop_addr_i,
  output logic             pf_req_o,
  output addr_t            pf_addr_o,
  input  logic             pf_ack_i,
  output logic             enabled_o,
  output logic             busy_o
);

  logic [CFG_W-1:0] base_q, throttle_q;
  hwpf_param_u      param_q;

  logic             busy_q, pf_req_q;
  logic [15:0]      cnt_q, thr_cnt_q;  // Prefetch index k, idle cycles
  logic [CFG_W-1:0] cursor_q;          // base + stride * k

  logic [CFG_W-1:0] base_addr, stride_ext;
  logic             trigger;

  assign base_addr  = {base_q[CFG_W-1:OFFS_W], {OFFS_W{1'b0}}};
  assign stride_ext = CFG_W'(param_q.fields.stride);

  assign trigger = base_q[0] && !busy_q && snoop_valid_i
                && (param_q.fields.nlines != '0)
                && (snoop_addr_i[ADDR_W-1:OFFS_W] == base_q[ADDR_W-1:OFFS_W]);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      base_q     <= '0;
      param_q    <= '0;
      throttle_q <= '0;
      busy_q     <= 1'b0;
      pf_req_q   <= 1'b0;
      cnt_q      <= '0;
      thr_cnt_q  <= '0;
      cursor_q   <= '0;
    end else begin
      if (trigger) begin
        busy_q    <= 1'b1;
        pf_req_q  <= 1'b1;
        cnt_q     <= 16'd1;
        thr_cnt_q <= '0;
        cursor_q  <= base_addr + stride_ext;
      end else if (busy_q) begin
        if (pf_req_q) begin
          if (pf_ack_i) pf_req_q <= 1'b0;
        end else if (!pf_ack_i) begin
          if (cnt_q == param_q.fields.nlines) begin
            // Done, next window starts after the last line, enable kept
            busy_q <= 1'b0;
            base_q <= {cursor_q[CFG_W-1:OFFS_W], base_q[OFFS_W-1:0]};
          end else if (thr_cnt_q == throttle_q[15:0]) begin
            thr_cnt_q <= '0;
            cnt_q     <= cnt_q + 16'd1;
            cursor_q  <= cursor_q + stride_ext;
            pf_req_q  <= 1'b1;
          end else begin
            thr_cnt_q <= thr_cnt_q + 16'd1;
          end
        end
      end
      // Software writes win
      if (base_set_i)     base_q      <= base_i;
      if (param_set_i)    param_q.raw <= param_i;
      if (throttle_set_i) throttle_q  <= throttle_i;
    end
  end

  assign base_o     = base_q;
  assign param_o    = param_q.raw;
  assign throttle_o = throttle_q;

  assign pf_req_o  = pf_req_q;
  assign pf_addr_o = cursor_q[ADDR_W-1:0];
  assign enabled_o = base_q[0];
  assign busy_o    = busy_q;

endmodule

//--- sim/tb_l1d_subsystem.sv
/*
 * Testbench for the L1 data-side subsystem
 *   - random loads, stores and flushes against a reference memory and tag shadow
 *   - prefetcher configuration readback and one stride prefetch run
 *   - memory port monitor, watchdog
 */
`timescale 1ns/1ps

module tb_l1d_subsystem import l1d_pkg::*; ();

  localparam int unsigned NrPf        = 2;
  localparam int unsigned Sets        = 16;
  localparam int unsigned NumOps      = 300;
  localparam int unsigned MaxOpCycles = 40;
  localparam int          ClkPeriod   = 20;
  localparam int          WatchdogNs  = (8 + (NumOps + 40) * MaxOpCycles) * ClkPeriod;

  logic  clk, rst_n;
  logic  ld_req, ld_ack, st_req, st_ack;
  addr_t ld_addr, st_addr, mem_addr;
  data_t ld_rdata, st_wdata, mem_wdata, mem_rdata;
  logic  mem_req, mem_we, mem_ack;
  logic  flush, flush_ack, miss;
  logic [1:0] mem_delay;

  logic [NrPf-1:0]            base_set, param_set, thr_set;
  logic [NrPf-1:0][CFG_W-1:0] base_in, param_in, thr_in;
  logic [NrPf-1:0][CFG_W-1:0] base_out, param_out, thr_out;
  logic [CFG_W-1:0]           status;

  // Monitor state
  logic [31:0] rd_cnt, wr_cnt, miss_cnt, flush_cnt;
  logic        mem_req_d;
  addr_t       last_wr_addr;
  data_t       last_wr_data;
  addr_t       rd_log [$];

  // Reference model
  data_t       ref_mem  [64];
  logic        sh_valid [Sets];
  logic [1:0]  sh_tag   [Sets];
  logic [31:0] rng;

  always #(ClkPeriod / 2) clk = ~clk;

  l1d_subsystem #(
    .NrHwPrefetchers (NrPf),
    .CacheSets       (Sets)
  ) i_l1d_subsystem (
    .clk_i               (clk),
    .rst_ni              (rst_n),
    .ld_req_i            (ld_req),
    .ld_addr_i           (ld_addr),
    .ld_ack_o            (ld_ack),
    .ld_rdata_o          (ld_rdata),
    .st_req_i            (st_req),
    .st_addr_i           (st_addr),
    .st_wdata_i          (st_wdata),
    .st_ack_o            (st_ack),
    .mem_req_o           (mem_req),
    .mem_we_o            (mem_we),
    .mem_addr_o          (mem_addr),
    .mem_wdata_o         (mem_wdata),
    .mem_ack_i           (mem_ack),
    .mem_rdata_i         (mem_rdata),
    .dcache_flush_i      (flush),
    .dcache_flush_ack_o  (flush_ack),
    .dcache_miss_o       (miss),
    .hwpf_base_set_i     (base_set),
    .hwpf_base_i         (base_in),
    .hwpf_base_o         (base_out),
    .hwpf_param_set_i    (param_set),
    .hwpf_param_i        (param_in),
    .hwpf_param_o        (param_out),
    .hwpf_throttle_set_i (thr_set),
    .hwpf_throttle_i     (thr_in),
    .hwpf_throttle_o     (thr_out),
    .hwpf_status_o       (status)
  );

  tb_mem_responder i_tb_mem_responder (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .mem_req_i   (mem_req),
    .mem_we_i    (mem_we),
    .mem_addr_i  (mem_addr),
    .mem_wdata_i (mem_wdata),
    .delay_i     (mem_delay),
    .mem_ack_o   (mem_ack),
    .mem_rdata_o (mem_rdata)
  );

  ////////////////////////////////////////
  // Memory port and event monitor
  ////////////////////////////////////////

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_req_d    <= 1'b0;
      rd_cnt       <= '0;
      wr_cnt       <= '0;
      miss_cnt     <= '0;
      flush_cnt    <= '0;
      last_wr_addr <= '0;
      last_wr_data <= '0;
    end else begin
      mem_req_d <= mem_req;
      if (mem_req && !mem_req_d) begin  // New memory transaction
        if (mem_we) begin
          wr_cnt       <= wr_cnt + 32'd1;
          last_wr_addr <= mem_addr;
          last_wr_data <= mem_wdata;
        end else begin
          rd_cnt <= rd_cnt + 32'd1;
          rd_log.push_back(mem_addr);
        end
      end
      if (miss)      miss_cnt  <= miss_cnt + 32'd1;
      if (flush_ack) flush_cnt <= flush_cnt + 32'd1;
    end
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // 16 sets, addresses below 512 bytes
  function automatic logic is_cached(input addr_t addr);
    return sh_valid[addr[6:3]] && (sh_tag[addr[6:3]] == addr[8:7]);
  endfunction

  task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
      $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
      $display("sim failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // All tasks start and end 1 ns after a rising edge
  task automatic write_cfg(input int unsigned eng, input logic [63:0] base,
                           input logic [63:0] param, input logic [63:0] thr);
    base_set[eng]  = 1'b1;
    param_set[eng] = 1'b1;
    thr_set[eng]   = 1'b1;
    base_in[eng]   = base;
    param_in[eng]  = param;
    thr_in[eng]    = thr;
    @(posedge clk);
    #1;
    base_set  = '0;
    param_set = '0;
    thr_set   = '0;
    check_eq("base readback", base, base_out[eng]);
    check_eq("param readback", param, param_out[eng]);
    check_eq("throttle readback", thr, thr_out[eng]);
    check_eq("status enable", 64'(base[0]), 64'(status[eng]));
  endtask

  task automatic load_word(input addr_t addr);
    logic        exp_miss;
    logic [31:0] rd0, miss0;
    exp_miss = !is_cached(addr);
    rd0      = rd_cnt;
    miss0    = miss_cnt;
    ld_addr  = addr;
    ld_req   = 1'b1;
    do begin
      @(posedge clk);
      #1;
    end while (!ld_ack);
    check_eq("load data", ref_mem[addr[8:3]], ld_rdata);
    ld_req = 1'b0;
    do begin
      @(posedge clk);
      #1;
    end while (ld_ack);
    @(posedge clk);
    #1;
    check_eq("load miss pulses", 64'(exp_miss), 64'(miss_cnt - miss0));
    check_eq("load mem reads", 64'(exp_miss), 64'(rd_cnt - rd0));
    if (exp_miss) begin
      sh_valid[addr[6:3]] = 1'b1;
      sh_tag[addr[6:3]]   = addr[8:7];
    end
  endtask

  task automatic store_word(input addr_t addr, input data_t data);
    logic [31:0] rd0, wr0;
    rd0      = rd_cnt;
    wr0      = wr_cnt;
    st_addr  = addr;
    st_wdata = data;
    st_req   = 1'b1;
    do begin
      @(posedge clk);
      #1;
    end while (!st_ack);
    st_req = 1'b0;
    do begin
      @(posedge clk);
      #1;
    end while (st_ack);
    @(posedge clk);
    #1;
    check_eq("store mem writes", 64'd1, 64'(wr_cnt - wr0));
    check_eq("store mem reads", 64'd0, 64'(rd_cnt - rd0));
    check_eq("store write addr", 64'(addr), 64'(last_wr_addr));
    check_eq("store write data", data, last_wr_data);
    ref_mem[addr[8:3]] = data;  // No allocate on a store miss
  endtask

  task automatic flush_cache();
    logic [31:0] fl0;
    fl0   = flush_cnt;
    flush = 1'b1;
    do begin
      @(posedge clk);
      #1;
    end while (!flush_ack);
    flush = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    check_eq("flush ack pulses", 64'd1, 64'(flush_cnt - fl0));
    for (int i = 0; i < Sets; i++) sh_valid[i] = 1'b0;
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin
    logic [31:0] r, miss0;
    int unsigned stride_b, nlines, thr_cyc, base_w;
    addr_t       pf_base, line;
    logic [63:0] pf_param, pf_thr;
    addr_t       exp_log [$];
    clk       = 1'b0;
    rst_n     = 1'b0;
    rng       = 32'ha05a;
    ld_req    = 1'b0;
    ld_addr   = '0;
    st_req    = 1'b0;
    st_addr   = '0;
    st_wdata  = '0;
    flush     = 1'b0;
    mem_delay = 2'd0;
    base_set  = '0;
    param_set = '0;
    thr_set   = '0;
    base_in   = '0;
    param_in  = '0;
    thr_in    = '0;
    for (int i = 0; i < Sets; i++) sh_valid[i] = 1'b0;
    for (int i = 0; i < Sets; i++) sh_tag[i] = 2'd0;
    repeat (8) @(posedge clk);
    #1 rst_n = 1'b1;
    for (int i = 0; i < 64; i++) ref_mem[i] = i_tb_mem_responder.mem[i];

    // Engine 1 gets nlines 0 so it never fires, engine 0 stays off
    write_cfg(1, {next_rand(), next_rand()}, {next_rand(), 16'h0, 16'(next_rand())},
              {next_rand(), next_rand()});
    write_cfg(0, {next_rand(), next_rand()} & ~64'd1, {next_rand(), next_rand()},
              {next_rand(), next_rand()});

    for (int i = 0; i < NumOps; i++) begin
      r         = next_rand();
      mem_delay = r[4:3];
      if (r[2:0] < 3'd4)       load_word({23'd0, r[10:5], 3'd0});
      else if (r[2:0] < 3'd7)  store_word({23'd0, r[10:5], 3'd0}, {next_rand(), next_rand()});
      else                     flush_cache();
    end

    // Stride prefetch window, lines stay in distinct sets
    r        = next_rand();
    stride_b = 8 * (1 + r % 3);
    nlines   = 2 + (r >> 4) % 3;
    thr_cyc  = (r >> 8) % 4;
    base_w   = (r >> 12) % 48;
    pf_base  = addr_t'(base_w * 8);
    pf_param = {32'h0, 16'(nlines), 16'(stride_b)};
    pf_thr   = {48'h0, 16'(thr_cyc)};
    write_cfg(0, 64'(pf_base) | 64'd1, pf_param, pf_thr);

    load_word(pf_base);
    miss0 = miss_cnt;
    rd_log.delete();
    check_eq("prefetch busy", 64'd1, 64'(status[32]));
    for (int unsigned k = 1; k <= nlines; k++) begin
      line = pf_base + addr_t'(stride_b * k);
      if (!is_cached(line)) begin
        exp_log.push_back(line);
        sh_valid[line[6:3]] = 1'b1;
        sh_tag[line[6:3]]   = line[8:7];
      end
    end
    while (status[32]) begin
      @(posedge clk);
      #1;
    end
    repeat (3) @(posedge clk);
    #1;
    check_eq("prefetch read count", 64'(exp_log.size()), 64'(rd_log.size()));
    foreach (exp_log[j]) check_eq("prefetch read addr", 64'(exp_log[j]), 64'(rd_log[j]));
    check_eq("prefetch miss pulses", 64'd0, 64'(miss_cnt - miss0));
    line = pf_base + addr_t'(stride_b * nlines);
    check_eq("advanced base", 64'(line) | 64'd1, base_out[0]);

    write_cfg(0, 64'(line), pf_param, pf_thr);  // Off before touching the new base
    for (int unsigned k = 1; k <= nlines; k++) load_word(pf_base + addr_t'(stride_b * k));

    $display("sim passed");
    $finish;
  end

  initial begin
    #(WatchdogNs);
    $display("Watchdog expired before all operations completed");
    $display("sim failed");
    $fatal(1, "timeout");
  end

endmodule

//--- sim/tb_mem_responder.sv
/*
 * Memory model for the DUT memory port
 *   - four-phase req/ack with a settable ack delay
 *   - 64 words, filled with a hash of the word address
 */
`timescale 1ns/1ps

module tb_mem_responder import l1d_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       mem_req_i,
  input  logic       mem_we_i,
  input  addr_t      mem_addr_i,
  input  data_t      mem_wdata_i,
  input  logic [1:0] delay_i,    // Cycles before ack
  output logic       mem_ack_o,
  output data_t      mem_rdata_o
);

  localparam int Words = 64;

  data_t mem [Words];

  // Odd multipliers keep every word distinct
  initial begin
    for (int i = 0; i < Words; i++) begin
      mem[i] = {~(32'(i) * 32'h9e37_79b9), (32'(i) * 32'h85eb_ca6b) ^ 32'hc2b2_ae35};
    end
  end

  initial begin
    logic [5:0] idx;
    mem_ack_o   = 1'b0;
    mem_rdata_o = '0;
    forever begin
      @(posedge clk_i);
      #1;
      if (rst_ni && mem_req_i) begin
        repeat (delay_i) begin
          @(posedge clk_i);
          #1;
        end
        idx = mem_addr_i[OFFS_W +: 6];
        if (mem_we_i) mem[idx] = mem_wdata_i;
        else          mem_rdata_o = mem[idx];
        mem_ack_o = 1'b1;
        do begin  // Hold ack until req drops
          @(posedge clk_i);
          #1;
        end while (mem_req_i);
        mem_ack_o = 1'b0;
      end
    end
  end

endmodule

//--- src/l1d_req_arbiter.sv
/*
 * Fixed-priority requester arbiter
 *   - store, then load, then prefetch
 *   - grant held until the winner's ack has fallen
 *   - snoop pulse on accepted demand accesses
 */
`timescale 1ns/1ps

module l1d_req_arbiter import l1d_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  st_req_i,
  input  addr_t st_addr_i,
  input  data_t st_wdata_i,
  output logic  st_ack_o,
  input  logic  ld_req_i,
  input  addr_t ld_addr_i,
  output logic  ld_ack_o,
  output data_t ld_rdata_o,
  input  logic  pf_req_i,
  input  addr_t pf_addr_i,
  output logic  pf_ack_o,
  output logic  core_req_o,
  output logic  core_we_o,
  output logic  core_pf_o,
  output addr_t core_addr_o,
  output data_t core_wdata_o,
  input  logic  core_ack_i,
  input  data_t core_rdata_i,
  output logic  snoop_valid_o,
  output addr_t snoop_addr_o
);

  logic [2:0] gnt_q, pick;  // One-hot {pf, ld, st}
  logic       core_ack_q;

  always_comb begin
    if (st_req_i)      pick = 3'b001;
    else if (ld_req_i) pick = 3'b010;
    else if (pf_req_i) pick = 3'b100;
    else               pick = 3'b000;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_q      <= '0;
      core_ack_q <= 1'b0;
    end else begin
      core_ack_q <= core_ack_i;
      if (gnt_q == '0) begin
        if (!core_ack_i) gnt_q <= pick;  // Previous transfer fully closed
      end else if (!core_req_o && !core_ack_i) begin
        gnt_q <= '0;
      end
    end
  end

  assign core_req_o   = |(gnt_q & {pf_req_i, ld_req_i, st_req_i});
  assign core_we_o    = gnt_q[0];
  assign core_pf_o    = gnt_q[2];
  assign core_addr_o  = gnt_q[0] ? st_addr_i : (gnt_q[1] ? ld_addr_i : pf_addr_i);
  assign core_wdata_o = st_wdata_i;

  // Ack only to the granted requester
  assign st_ack_o   = gnt_q[0] & core_ack_i;
  assign ld_ack_o   = gnt_q[1] & core_ack_i;
  assign pf_ack_o   = gnt_q[2] & core_ack_i;
  assign ld_rdata_o = core_rdata_i;

  // Rising ack of a demand access
  assign snoop_valid_o = core_ack_i & ~core_ack_q & (gnt_q[0] | gnt_q[1]);
  assign snoop_addr_o  = core_addr_o;

endmodule

//--- src/l1d_subsystem.sv
/*
 * L1 data-side top level
 *   - store/load/prefetch request arbiter
 *   - write-through direct-mapped data cache
 *   - stride hardware prefetchers
 */
`timescale 1ns/1ps

module l1d_subsystem import l1d_pkg::*; #(
  parameter int unsigned NrHwPrefetchers = 2,
  parameter int unsigned CacheSets       = 16
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  // Load port
  input  logic                                  ld_req_i,
  input  addr_t                                 ld_addr_i,
  output logic                                  ld_ack_o,
  output data_t                                 ld_rdata_o,
  // Store port
  input  logic                                  st_req_i,
  input  addr_t                                 st_addr_i,
  input  data_t                                 st_wdata_i,
  output logic                                  st_ack_o,
  // Memory port
  output logic                                  mem_req_o,
  output logic                                  mem_we_o,
  output addr_t                                 mem_addr_o,
  output data_t                                 mem_wdata_o,
  input  logic                                  mem_ack_i,
  input  data_t                                 mem_rdata_i,
  // Cache management
  input  logic                                  dcache_flush_i,
  output logic                                  dcache_flush_ack_o,
  output logic                                  dcache_miss_o,
  // Prefetcher configuration
  input  logic [NrHwPrefetchers-1:0]            hwpf_base_set_i,
  input  logic [NrHwPrefetchers-1:0][CFG_W-1:0] hwpf_base_i,
  output logic [NrHwPrefetchers-1:0][CFG_W-1:0] hwpf_base_o,
  input  logic [NrHwPrefetchers-1:0]            hwpf_param_set_i,
  input  logic [NrHwPrefetchers-1:0][CFG_W-1:0] hwpf_param_i,
  output logic [NrHwPrefetchers-1:0][CFG_W-1:0] hwpf_param_o,
  input  logic [NrHwPrefetchers-1:0]            hwpf_throttle_set_i,
  input  logic [NrHwPrefetchers-1:0][CFG_W-1:0] hwpf_throttle_i,
  output logic [NrHwPrefetchers-1:0][CFG_W-1:0] hwpf_throttle_o,
  output logic [CFG_W-1:0]                      hwpf_status_o
);

  // Arbiter to cache
  logic  core_req, core_we, core_pf, core_ack;
  addr_t core_addr;
  data_t core_wdata, core_rdata;

  // Prefetcher to arbiter, and snoop back
  logic  pf_req, pf_ack, snoop_valid;
  addr_t pf_addr, snoop_addr;

  l1d_req_arbiter i_l1d_req_arbiter (
    .clk_i,
    .rst_ni,
    .st_req_i,
    .st_addr_i,
    .st_wdata_i,
    .st_ack_o,
    .ld_req_i,
    .ld_addr_i,
    .ld_ack_o,
    .ld_rdata_o,
    .pf_req_i      (pf_req),
    .pf_addr_i     (pf_addr),
    .pf_ack_o      (pf_ack),
    .core_req_o    (core_req),
    .core_we_o     (core_we),
    .core_pf_o     (core_pf),
    .core_addr_o   (core_addr),
    .core_wdata_o  (core_wdata),
    .core_ack_i    (core_ack),
    .core_rdata_i  (core_rdata),
    .snoop_valid_o (snoop_valid),
    .snoop_addr_o  (snoop_addr)
  );

  dcache_ctrl #(
    .CacheSets (CacheSets)
  ) i_dcache_ctrl (
    .clk_i,
    .rst_ni,
    .core_req_i   (core_req),
    .core_we_i    (core_we),
    .core_pf_i    (core_pf),
    .core_addr_i  (core_addr),
    .core_wdata_i (core_wdata),
    .core_ack_o   (core_ack),
    .core_rdata_o (core_rdata),
    .flush_i      (dcache_flush_i),
    .flush_ack_o  (dcache_flush_ack_o),
    .miss_o       (dcache_miss_o),
    .mem_req_o,
    .mem_we_o,
    .mem_addr_o,
    .mem_wdata_o,
    .mem_ack_i,
    .mem_rdata_i
  );

  hwpf_stride_arbiter #(
    .NrHwPrefetchers (NrHwPrefetchers)
  ) i_hwpf_stride_arbiter (
    .clk_i,
    .rst_ni,
    .hwpf_base_set_i,
    .hwpf_base_i,
    .hwpf_base_o,
    .hwpf_param_set_i,
    .hwpf_param_i,
    .hwpf_param_o,
    .hwpf_throttle_set_i,
    .hwpf_throttle_i,
    .hwpf_throttle_o,
    .hwpf_status_o,
    .snoop_valid_i (snoop_valid),
    .snoop_addr_i  (snoop_addr),
    .pf_req_o      (pf_req),
    .pf_addr_o     (pf_addr),
    .pf_ack_i      (pf_ack)
  );

endmodule

//--- tb.f
common/l1d_pkg.sv
dcache/dcache_array.sv
dcache/dcache_ctrl.sv
hwpf/hwpf_stride_engine.sv
hwpf/hwpf_stride_arbiter.sv
src/l1d_req_arbiter.sv
src/l1d_subsystem.sv
sim/tb_mem_responder.sv
sim/tb_l1d_subsystem.sv
